//--- bit_corr/corr_adder_chain.sv
/* systolic adder chain that forms the correlation for every slot
   stage j adds the signed sample to stage j-1's sum from the previous beat */
`timescale 1ns/10ps

module corr_adder_chain import bit_corr_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall,
  input  logic                          seq_valid,
  input  logic signed [wave_width-1:0]  seq_sample,
  input  logic [slot_width-1:0]         seq_slot,
  output logic                          sum_valid,
  output logic signed [adder_width-1:0] sum_value,
  output logic [slot_width-1:0]         sum_slot
);

  // first pipeline step, sample beside the memory read
  logic                         p1_valid;
  logic signed [wave_width-1:0] p1_sample;
  logic [slot_width-1:0]        p1_slot;

  // second pipeline step, registered adders
  logic                  s2_valid;
  logic [slot_width-1:0] s2_slot;

  logic [corr_length-1:0]        code_sel;
  logic signed [adder_width-1:0] sample_ext;
  logic signed [adder_width-1:0] prev_sum [corr_length];
  logic signed [adder_width-1:0] adder_in [corr_length];
  logic signed [adder_width-1:0] adder_out [corr_length];

  //////////////////////////////////////////////////////////////////////
  // stage valids
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      p1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall) begin
      p1_valid <= seq_valid;
      s2_valid <= p1_valid;
    end
  end

  // payload follows the valids, no reset
  always_ff @(posedge clk) begin
    if (!stall) begin
      if (seq_valid) begin
        p1_sample <= seq_sample;
        p1_slot <= seq_slot;
      end
      if (p1_valid) begin
        s2_slot <= p1_slot;
        for (int j = 0; j < corr_length; j++) begin
          adder_out[j] <= adder_in[j];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // delay memories between stages
  //////////////////////////////////////////////////////////////////////

  // first stage starts from zero
  assign prev_sum[0] = '0;

  for (genvar j = 1; j < corr_length; j++) begin : g_delay
    // read with the incoming slot, write back two cycles on
    corr_delay_ram u_delay_ram (
      .clk     (clk),
      .wr_en   (sum_valid),
      .wr_addr (s2_slot),
      .wr_data (adder_out[j-1]),
      .rd_en   (seq_valid),
      .rd_addr (seq_slot),
      .rd_data (prev_sum[j])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // adders
  //////////////////////////////////////////////////////////////////////

  // code row for the slot in flight
  assign code_sel = corr_codes[dest_width'(p1_slot / num_parallel)];
  assign sample_ext = adder_width'(p1_sample);

  // stage j uses the bit corr_length-1-j, so the tail holds bit 0
  always_comb begin
    for (int j = 0; j < corr_length; j++) begin
      if (code_sel[corr_length-1-j]) begin
        adder_in[j] = prev_sum[j] + sample_ext;
      end else begin
        adder_in[j] = prev_sum[j] - sample_ext;
      end
    end
  end

  // last stage carries the finished correlation
  assign sum_valid = s2_valid & ~stall;
  assign sum_value = adder_out[corr_length-1];
  assign sum_slot = s2_slot;

  a_slot_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_valid |-> !$isunknown(sum_slot)
  );

endmodule

//--- bit_corr/corr_delay_ram.sv
/* one-write one-read delay memory, one entry per slot
   keeps a stage's partial sum until the same slot comes round on the next beat */
`timescale 1ns/10ps

module corr_delay_ram import bit_corr_pkg::*; (
  input  logic                          clk,
  input  logic                          wr_en,
  input  logic [slot_width-1:0]         wr_addr,
  input  logic signed [adder_width-1:0] wr_data,
  input  logic                          rd_en,
  input  logic [slot_width-1:0]         rd_addr,
  output logic signed [adder_width-1:0] rd_data
);

  // inferred storage
  logic signed [adder_width-1:0] mem [num_slots];

  // empty history at power up
  // samples before the first beat count as zero
  initial begin
    for (int i = 0; i < num_slots; i++) begin
      mem[i] = '0;
    end
  end

  // write port
  // read port is registered, old data on a same-address collision
  always @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- bit_corr_top.f
common/bit_corr_pkg.sv
bit_corr/corr_delay_ram.sv
bit_corr/corr_adder_chain.sv
source/corr_sequencer.sv
source/corr_output_stage.sv
source/bit_corr_top.sv
sim/bit_corr_tb.sv

//--- common/bit_corr_pkg.sv
/* shared constants for the streaming bit correlator
   widths, slot layout and the fixed code table, imported by the RTL and the testbench */

package bit_corr_pkg;

  //////////////////////////////////////////////////////////////////////
  // stream geometry
  //////////////////////////////////////////////////////////////////////

  // channels per beat, one signed sample each
  localparam int num_parallel = 4;
  // signed input sample width
  localparam int wave_width = 6;
  // signed sum width, covers corr_length * 32 with margin
  localparam int adder_width = 12;

  //////////////////////////////////////////////////////////////////////
  // correlator shape
  //////////////////////////////////////////////////////////////////////

  // code length in bits
  localparam int corr_length = 8;
  // number of codes
  localparam int num_corrs = 2;

  // one slot per code/channel pair, all channels of code 0 first
  localparam int num_slots = num_corrs * num_parallel;
  localparam int slot_width = (num_slots > 1) ? $clog2(num_slots) : 1;
  // channel index inside a slot
  localparam int chan_width = (num_parallel > 1) ? $clog2(num_parallel) : 1;
  // code index carried on m_tdest
  localparam int dest_width = (num_corrs > 1) ? $clog2(num_corrs) : 1;

  // packed stream widths
  localparam int slave_width = wave_width * num_parallel;
  localparam int master_width = adder_width * num_parallel;

  //////////////////////////////////////////////////////////////////////
  // code table
  //////////////////////////////////////////////////////////////////////

  // bit i of code k weights the sample from i beats back
  // bit set means +1, bit clear means -1
  // corr_codes[k] is code k, so code 0 sits in the low half
  localparam logic [num_corrs-1:0][corr_length-1:0] corr_codes = {
    8'b1101_0010,
    8'b1110_0100
  };

endpackage

//--- run_sim.sh
#!/bin/sh
# builds the bit correlator testbench with Verilator and runs it
# exit status is zero only when the pass line appears in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module bit_corr_tb \
  -f bit_corr_top.f -o bit_corr_sim &&
  ./obj_dir/bit_corr_sim | tee /dev/stderr | grep -q "^RESULT: PASS$" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

//--- sim/bit_corr_tb.sv
/* testbench for the streaming bit correlator
   drives random and fixed beats and checks every output beat against a direct correlation sum */
`timescale 1ns/10ps

module bit_corr_tb import bit_corr_pkg::*; ();

  localparam int num_beats = 200;
  localparam int wait_limit = 2000;

  logic                    clk;
  logic                    rst_n;
  logic                    s_tvalid;
  logic                    s_tready;
  logic [slave_width-1:0]  s_tdata;
  logic                    m_tvalid;
  logic                    m_tready;
  logic [master_width-1:0] m_tdata;
  logic [dest_width-1:0]   m_tdest;

  // per-channel sample history with index 0 as the newest beat
  int hist [num_parallel][corr_length];

  // expected output beats in arrival order
  logic [master_width-1:0] exp_data_q [$];
  logic [dest_width-1:0]   exp_dest_q [$];

  logic [slave_width-1:0]  stream_beats [num_beats];
  logic                    ready_random;
  logic                    held_valid;
  logic [master_width-1:0] held_data;
  logic [dest_width-1:0]   held_dest;
  int check_count;
  int error_count;
  int timeout_count;
  int out_count;

  bit_corr_top DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tdata  (m_tdata),
    .m_tdest  (m_tdest)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////
  // reference and checking
  ////////////////////////////////////////////////////////////////////////

  // direct sum over the last corr_length samples of each channel
  function automatic logic [master_width-1:0] expected_word(input int k);
    logic [master_width-1:0] word;
    int acc;
    word = '0;
    for (int c = 0; c < num_parallel; c++) begin
      acc = 0;
      for (int i = 0; i < corr_length; i++) begin
        // bit i weights the sample from i beats back
        if (corr_codes[k][i]) begin
          acc += hist[c][i];
        end else begin
          acc -= hist[c][i];
        end
      end
      // a sum outside adder_width would wrap in the DUT
      if (acc > 2 ** (adder_width - 1) - 1 || acc < -(2 ** (adder_width - 1))) begin
        $display("reference sum %0d does not fit in %0d signed bits", acc, adder_width);
        error_count++;
      end
      word[c*adder_width +: adder_width] = acc[adder_width-1:0];
    end
    return word;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  // same sample on every channel
  function automatic logic [slave_width-1:0] fill_beat(input int value);
    logic [slave_width-1:0] beat;
    for (int c = 0; c < num_parallel; c++) begin
      beat[c*wave_width +: wave_width] = value[wave_width-1:0];
    end
    return beat;
  endfunction

  // both streams sampled mid-cycle while nothing moves
  always @(negedge clk) begin
    if (rst_n) begin
      // input transfer at the coming edge updates history and expectations
      if (s_tvalid && s_tready) begin
        for (int c = 0; c < num_parallel; c++) begin
          for (int i = corr_length - 1; i > 0; i--) begin
            hist[c][i] = hist[c][i-1];
          end
          hist[c][0] = $signed(s_tdata[c*wave_width +: wave_width]);
        end
        for (int k = 0; k < num_corrs; k++) begin
          exp_data_q.push_back(expected_word(k));
          exp_dest_q.push_back(dest_width'(k));
        end
      end
      // held word must not move while waiting
      if (held_valid) begin
        check_value("m_tvalid", 64'(m_tvalid), 64'(1));
        check_value("m_tdata", 64'(m_tdata), 64'(held_data));
        check_value("m_tdest", 64'(m_tdest), 64'(held_dest));
      end
      held_valid = m_tvalid && !m_tready;
      held_data = m_tdata;
      held_dest = m_tdest;
      // output transfer at the coming edge
      if (m_tvalid && m_tready) begin
        out_count++;
        if (exp_data_q.size() == 0) begin
          $display("an output beat arrived with no input beat left to match it");
          error_count++;
        end else begin
          check_value("m_tdest", 64'(m_tdest), 64'(exp_dest_q.pop_front()));
          check_value("m_tdata", 64'(m_tdata), 64'(exp_data_q.pop_front()));
        end
      end
    end
  end

  // output back-pressure either random or always ready
  always @(posedge clk) begin
    #2;
    if (ready_random) begin
      m_tready = ($urandom_range(99, 0) < 60);
    end else begin
      m_tready = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////

  // holds the beat until s_tready is seen
  // starts and ends 2 ns after an edge
  task automatic send_beat(input logic [slave_width-1:0] data);
    int waited;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    s_tvalid = 1'b1;
    s_tdata = data;
    while (!accepted && waited < wait_limit) begin
      @(negedge clk);
      accepted = s_tready;
      @(posedge clk);
      #2;
      waited++;
    end
    if (!accepted) begin
      $display("timeout: input beat was never accepted");
      timeout_count++;
    end
    s_tvalid = 1'b0;
  endtask

  task automatic send_stream(input logic with_gaps);
    int gap;
    for (int n = 0; n < num_beats; n++) begin
      if (with_gaps) begin
        gap = ($urandom_range(3, 0) == 0) ? int'($urandom_range(4, 1)) : 0;
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
      send_beat(stream_beats[n]);
    end
  endtask

  // all expected beats must come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && waited < wait_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_data_q.size() != 0) begin
      $display("timeout: %0d output beats never arrived", exp_data_q.size());
      timeout_count++;
    end
    #2;
  endtask

  initial begin
    logic [slave_width-1:0] beat;
    void'($urandom(32'h458b8edd));
    clk = 1'b0;
    rst_n = 1'b0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    m_tready = 1'b1;
    ready_random = 1'b0;
    held_valid = 1'b0;
    held_data = '0;
    held_dest = '0;
    check_count = 0;
    error_count = 0;
    timeout_count = 0;
    out_count = 0;
    for (int c = 0; c < num_parallel; c++) begin
      for (int i = 0; i < corr_length; i++) begin
        hist[c][i] = 0;
      end
    end
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // idle state straight out of reset
    @(negedge clk);
    check_value("m_tvalid", 64'(m_tvalid), 64'(0));
    check_value("s_tready", 64'(s_tready), 64'(1));
    @(posedge clk);
    #2;

    // one known beat on an empty history
    beat = {6'sd17, -6'sd32, -6'sd3, 6'sd5};
    send_beat(beat);
    wait_drain();
    repeat (num_slots + 4) @(posedge clk);
    #2;
    check_value("output beat count", 64'(out_count), 64'(num_corrs));

    // random stream with no gaps and the sink always ready
    for (int n = 0; n < num_beats; n++) begin
      for (int c = 0; c < num_parallel; c++) begin
        beat[c*wave_width +: wave_width] = wave_width'($urandom_range(63, 0));
      end
      stream_beats[n] = beat;
    end
    send_stream(1'b0);
    wait_drain();

    // same stream with gaps and a stalling sink
    ready_random = 1'b1;
    send_stream(1'b1);
    wait_drain();
    ready_random = 1'b0;

    // extreme samples over a full history of each
    repeat (corr_length) send_beat(fill_beat(31));
    repeat (corr_length) send_beat(fill_beat(-32));
    // samples matched to code 0 give its largest sum
    for (int j = 0; j < corr_length; j++) begin
      send_beat(fill_beat(corr_codes[0][corr_length-1-j] ? 31 : -32));
    end
    wait_drain();
    repeat (num_slots + 4) @(posedge clk);

    $display("checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- source/bit_corr_top.sv
/* top of the streaming bit correlator
   sequencer, adder chain and output stage in pipeline order, wiring only */
`timescale 1ns/10ps

module bit_corr_top import bit_corr_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  // input stream, channel c at bits c*wave_width upward
  input  logic                    s_tvalid,
  output logic                    s_tready,
  input  logic [slave_width-1:0]  s_tdata,
  // output stream, one beat per code
  output logic                    m_tvalid,
  input  logic                    m_tready,
  output logic [master_width-1:0] m_tdata,
  output logic [dest_width-1:0]   m_tdest
);

  //////////////////////////////////////////////////////////////////////
  // inter-stage wires
  //////////////////////////////////////////////////////////////////////

  // sequencer to chain
  logic                          seq_valid;
  logic signed [wave_width-1:0]  seq_sample;
  logic [slot_width-1:0]         seq_slot;

  // chain to output stage
  logic                          sum_valid;
  logic signed [adder_width-1:0] sum_value;
  logic [slot_width-1:0]         sum_slot;

  // back-pressure from the output buffer
  logic                          stall;

  corr_sequencer u_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .stall      (stall),
    .seq_valid  (seq_valid),
    .seq_sample (seq_sample),
    .seq_slot   (seq_slot)
  );

  corr_adder_chain u_adder_chain (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .seq_valid  (seq_valid),
    .seq_sample (seq_sample),
    .seq_slot   (seq_slot),
    .sum_valid  (sum_valid),
    .sum_value  (sum_value),
    .sum_slot   (sum_slot)
  );

  corr_output_stage u_output_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .sum_valid (sum_valid),
    .sum_value (sum_value),
    .sum_slot  (sum_slot),
    .stall     (stall),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tdata   (m_tdata),
    .m_tdest   (m_tdest)
  );

endmodule

//--- source/corr_output_stage.sv
/* output side of the correlator
   packs per-slot sums into one word per code and drives the output stream with a two-deep buffer */
`timescale 1ns/10ps

module corr_output_stage import bit_corr_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          sum_valid,
  input  logic signed [adder_width-1:0] sum_value,
  input  logic [slot_width-1:0]         sum_slot,
  output logic                          stall,
  output logic                          m_tvalid,
  input  logic                          m_tready,
  output logic [master_width-1:0]       m_tdata,
  output logic [dest_width-1:0]         m_tdest
);

  // slot decode
  logic [chan_width-1:0] lane;
  logic [dest_width-1:0] code;
  logic                  word_done;

  // collect register, one lane per channel
  logic signed [adder_width-1:0] collect [num_parallel];
  logic [master_width-1:0]       assembled;

  // penultimate register
  logic                    pen_valid;
  logic [master_width-1:0] pen_data;
  logic [dest_width-1:0]   pen_dest;

  logic m_xfer;
  logic m_load;

  //////////////////////////////////////////////////////////////////////
  // word assembly
  //////////////////////////////////////////////////////////////////////

  assign lane = chan_width'(sum_slot % num_parallel);
  assign code = dest_width'(sum_slot / num_parallel);

  // last channel closes the word for this code
  assign word_done = sum_valid & (lane == chan_width'(num_parallel - 1));

  always_ff @(posedge clk) begin
    if (sum_valid) begin
      collect[lane] <= sum_value;
    end
  end

  // incoming sum bypasses its lane so the word is whole on the last channel
  always_comb begin
    for (int n = 0; n < num_parallel; n++) begin
      if (sum_valid && lane == chan_width'(n)) begin
        assembled[n*adder_width +: adder_width] = sum_value;
      end else begin
        assembled[n*adder_width +: adder_width] = collect[n];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // two-deep output buffer
  //////////////////////////////////////////////////////////////////////

  assign m_xfer = m_tvalid & m_tready;
  // m register free or draining this cycle
  assign m_load = ~m_tvalid | m_xfer;

  // both full and nothing leaving, so hold the pipeline
  assign stall = pen_valid & m_tvalid & ~m_xfer;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pen_valid <= 1'b0;
      m_tvalid <= 1'b0;
    end else begin
      if (word_done) begin
        pen_valid <= 1'b1;
      end else if (m_load) begin
        pen_valid <= 1'b0;
      end
      if (m_load) begin
        m_tvalid <= pen_valid;
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (word_done) begin
      pen_data <= assembled;
      pen_dest <= code;
    end
    if (m_load) begin
      m_tdata <= pen_data;
      m_tdest <= pen_dest;
    end
  end

  // held word stays put until taken
  a_m_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tdest)
  );

endmodule

//--- source/corr_sequencer.sv
/* input side of the correlator
   latches one stream beat and walks through every code/channel slot at one per cycle */
`timescale 1ns/10ps

module corr_sequencer import bit_corr_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  logic [slave_width-1:0]       s_tdata,
  input  logic                         stall,
  output logic                         seq_valid,
  output logic signed [wave_width-1:0] seq_sample,
  output logic [slot_width-1:0]        seq_slot
);

  // control state
  logic                  busy;
  logic [slot_width-1:0] slot;
  logic                  last_slot;
  logic                  s_xfer;
  logic [chan_width-1:0] chan;

  // accepted beat split into channel lanes
  logic signed [wave_width-1:0] beat_lane [num_parallel];

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign last_slot = (slot == slot_width'(num_slots - 1));

  // next beat may land while the last slot goes out
  assign s_tready = ~stall & (~busy | last_slot);
  assign s_xfer = s_tvalid & s_tready;

  // slot counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      slot <= '0;
    end else if (s_xfer) begin
      busy <= 1'b1;
      slot <= '0;
    end else if (busy && !stall) begin
      if (last_slot) begin
        busy <= 1'b0;
      end else begin
        slot <= slot + 1'b1;
      end
    end
  end

  // beat storage loads on transfer only
  always_ff @(posedge clk) begin
    if (s_xfer) begin
      for (int c = 0; c < num_parallel; c++) begin
        beat_lane[c] <= s_tdata[c*wave_width +: wave_width];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // slot issue
  //////////////////////////////////////////////////////////////////////

  // channel part of the slot index
  assign chan = chan_width'(slot % num_parallel);

  // strobe drops while the pipeline is frozen
  assign seq_valid = busy & ~stall;
  assign seq_sample = beat_lane[chan];
  assign seq_slot = slot;

  // counter and held beat stay put while the chain is frozen
  a_frozen_in_stall : assert property (
    @(posedge clk) disable iff (!rst_n)
    stall |=> $stable(busy) && $stable(slot) && $stable(seq_sample)
  );

endmodule
